// ==== hdl/uartTxPkg.sv ====
// uart transmit bank definitions
`default_nettype none

package uartTxPkg;

	////////////////////////////////////////////////////////////
	// bank geometry and frame format
	////////////////////////////////////////////////////////////

	localparam int numChannels = 4;		// transmit channels in the bank
	localparam int chanIdxLen  = 2;		// log2(numChannels)
	localparam int dataBits    = 8;		// payload bits per frame
	localparam int sbTick      = 16;	// oversampling ticks in one stop bit
	localparam int tickCntLen  = 4;		// counts 16 ticks per bit
	localparam int bitCntLen   = 3;		// counts dataBits data bits

	// per channel byte queue
	localparam int fifoDepth   = 16;
	localparam int fifoAddrLen = 4;
	localparam int fifoCntLen  = 5;		// level 0..16 needs the extra bit

	// baud divisor, one tick every divisor+1 clocks
	localparam int divisorLen = 15;
	localparam logic [divisorLen-1:0] defaultDivisor = 15'd3;	// 4 clocks per tick

	////////////////////////////////////////////////////////////
	// host word, tag in the msb picks the view
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                  isConfig;	// 0 for a data word
		logic [4:0]            pad;
		logic [chanIdxLen-1:0] channel;		// target channel
		logic [dataBits-1:0]   payload;		// byte to queue
	} hostData_t;

	typedef struct packed {
		logic                  isConfig;	// 1 for a divisor write
		logic [divisorLen-1:0] divisor;
	} hostConfig_t;

	typedef union packed {
		hostData_t   data;
		hostConfig_t cfg;
	} hostWord_t;

	// one channel's status as seen by the host
	typedef struct packed {
		logic                  overflow;	// pulse in channel, sticky in collector
		logic                  busy;		// fifo holds data or frame in flight
		logic                  empty;
		logic [fifoCntLen-1:0] level;
	} chanStatus_t;

endpackage

`default_nettype wire

// ==== hdl/baudTickGen.sv ====
// shared oversampling tick
`default_nettype none

module baudTickGen (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             divLoad,	// config write strobe
	input  logic [uartTxPkg::divisorLen-1:0] divValue,
	output logic                             sTick
);
	import uartTxPkg::*;

	logic [divisorLen-1:0] divReg;	// current divisor
	logic [divisorLen-1:0] cntReg;	// counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divReg <= defaultDivisor;
			cntReg <= defaultDivisor;	// keeps sTick low out of reset
		end
		else if (divLoad)
		begin
			divReg <= divValue;
			cntReg <= divValue;		// restart the count with the new rate
		end
		else if (cntReg == '0)
			cntReg <= divReg;		// wrap, reload
		else
			cntReg <= cntReg - 1'b1;
	end

	// one cycle pulse at the wrap
	assign sTick = (cntReg == '0);

	// with a nonzero divisor the tick is always a single cycle
	assert property (@(posedge clk) disable iff (reset)
		(sTick && divReg != '0 && !divLoad) |=> !sTick);

endmodule

`default_nettype wire

// ==== hdl/uartTrans.sv ====
// serial transmitter fsm
`default_nettype none

module uartTrans (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           sTick,		// 16x oversampling tick
	input  logic                           txStart,		// level, byte waiting
	input  logic [uartTxPkg::dataBits-1:0] din,
	output logic                           tx,
	output logic                           txDoneTick,	// pops the fifo
	output logic                           txIdle		// fsm sits in idle
);
	import uartTxPkg::*;

	typedef enum logic [1:0] {
		idle  = 2'b00,
		start = 2'b01,
		data  = 2'b10,
		stop  = 2'b11
	} txState_t;

	txState_t               stateReg, stateNext;
	logic [tickCntLen-1:0]  sReg, sNext;	// ticks within a bit
	logic [bitCntLen-1:0]   nReg, nNext;	// data bit index
	logic [dataBits-1:0]    bReg, bNext;	// shift register, lsb goes out first
	logic                   txReg, txNext;	// registered line

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	// payload only, loaded on accept
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// pop now
					bNext      = din;	// fifo head still valid this cycle
					sNext      = '0;
					stateNext  = start;
				end
			end
			start:
			begin
				txNext = 1'b0;			// start bit
				if (sTick)
				begin
					if (sReg == '1)
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == '1)
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit to lsb
						if (nReg == bitCntLen'(dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			stop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == tickCntLen'(sbTick - 1))
						stateNext = idle;
					else
						sNext = sReg + 1'b1;
				end
			end
			default:
				stateNext = idle;
		endcase
	end

	assign tx     = txReg;
	assign txIdle = (stateReg == idle);

	// pop only on an accepted start, and the line rests high between frames
	assert property (@(posedge clk) disable iff (reset)
		txDoneTick |-> (txStart && stateReg == idle));
	assert property (@(posedge clk) disable iff (reset)
		(stateReg == idle) |-> tx);

endmodule

`default_nettype wire

// ==== hdl/txChannel.sv ====
// one transmit channel with byte fifo
`default_nettype none

module txChannel (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           sTick,
	input  logic                           push,		// host write for this channel
	input  logic [uartTxPkg::dataBits-1:0] pushData,
	output logic                           tx,
	output uartTxPkg::chanStatus_t         chanStatus
);
	import uartTxPkg::*;

	logic [dataBits-1:0]    mem [fifoDepth];	// no reset on storage
	logic [fifoAddrLen-1:0] wrPtr, rdPtr;
	logic [fifoCntLen-1:0]  level;
	logic                   full, empty;
	logic                   pushOk, pop;
	logic                   overflowPulse;
	logic                   txDoneTick, txIdle;

	assign full   = (level == fifoCntLen'(fifoDepth));
	assign empty  = (level == '0);
	assign pushOk = push && !full;	// a full fifo drops the byte
	assign pop    = txDoneTick;		// only fires while not empty

	////////////////////////////////////////////////////////////
	// circular fifo
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (pushOk)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr         <= '0;
			rdPtr         <= '0;
			level         <= '0;
			overflowPulse <= 1'b0;
		end
		else
		begin
			if (pushOk)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({pushOk, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;	// both or neither
			endcase
			overflowPulse <= push && full;	// one cycle per dropped write
		end
	end

	// transmitter pulls straight from the fifo head
	uartTrans u_trans (
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.txStart    (!empty),
		.din        (mem[rdPtr]),
		.tx         (tx),
		.txDoneTick (txDoneTick),
		.txIdle     (txIdle)
	);

	assign chanStatus.overflow = overflowPulse;
	assign chanStatus.busy     = !empty || !txIdle;
	assign chanStatus.empty    = empty;
	assign chanStatus.level    = level;

	assert property (@(posedge clk) disable iff (reset)
		level <= fifoCntLen'(fifoDepth));

endmodule

`default_nettype wire

// ==== hdl/hostPort.sv ====
// host word decoder
`default_nettype none

module hostPort (
	input  logic                                hostWr,		// write strobe
	input  uartTxPkg::hostWord_t                hostWord,
	output logic [uartTxPkg::numChannels-1:0]   push,		// one bit per channel
	output logic [uartTxPkg::dataBits-1:0]      pushData,
	output logic                                divLoad,
	output logic [uartTxPkg::divisorLen-1:0]    divValue
);
	import uartTxPkg::*;

	logic isConfig;	// union tag, same bit in both views

	assign isConfig = hostWord.data.isConfig;

	////////////////////////////////////////////////////////////
	// data view, channel select to push strobe
	////////////////////////////////////////////////////////////

	always_comb
	begin
		push = '0;
		if (hostWr && !isConfig)
			push[hostWord.data.channel] = 1'b1;
	end

	assign pushData = hostWord.data.payload;	// only taken where push is set

	////////////////////////////////////////////////////////////
	// config view, divisor load
	////////////////////////////////////////////////////////////

	assign divLoad  = hostWr && isConfig;
	assign divValue = hostWord.cfg.divisor;

	// no clock here, checked as the decode settles
	always_comb
	begin
		assert ($onehot0(push))
		else
			$error("hostPort push not one hot");
	end

endmodule

`default_nettype wire

// ==== hdl/statusCollector.sv ====
// channel status collector
`default_nettype none

module statusCollector (
	input  logic                               clk,
	input  logic                               reset,
	input  uartTxPkg::chanStatus_t             chanStatusIn [uartTxPkg::numChannels],
	input  logic [uartTxPkg::chanIdxLen-1:0]   statusSel,
	input  logic                               statusRd,	// clears selected sticky flag
	output uartTxPkg::chanStatus_t             status
);
	import uartTxPkg::*;

	logic [numChannels-1:0] stickyOvf;	// one per channel
	chanStatus_t            selStatus;

	////////////////////////////////////////////////////////////
	// sticky overflow flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			stickyOvf <= '0;
		else
		begin
			for (int i = 0; i < numChannels; i++)
			begin
				if (chanStatusIn[i].overflow)
					stickyOvf[i] <= 1'b1;	// new drop beats a clear
				else if (statusRd && statusSel == chanIdxLen'(i))
					stickyOvf[i] <= 1'b0;
			end
		end
	end

	// pick the channel, fold in its sticky flag
	always_comb
	begin
		selStatus          = chanStatusIn[statusSel];
		selStatus.overflow = stickyOvf[statusSel] | chanStatusIn[statusSel].overflow;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			status <= '{overflow: 1'b0, busy: 1'b0, empty: 1'b1, level: '0};
		else
			status <= selStatus;	// one cycle behind statusSel
	end

endmodule

`default_nettype wire

// ==== hdl/uartTxBank.sv ====
// four channel uart transmit bank
`default_nettype none

module uartTxBank (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               hostWr,
	input  uartTxPkg::hostWord_t               hostWord,
	input  logic [uartTxPkg::chanIdxLen-1:0]   statusSel,
	input  logic                               statusRd,
	output uartTxPkg::chanStatus_t             status,
	output logic [uartTxPkg::numChannels-1:0]  tx		// one line per channel
);
	import uartTxPkg::*;

	logic [numChannels-1:0] push;
	logic [dataBits-1:0]    pushData;	// shared, push picks the channel
	logic                   divLoad;
	logic [divisorLen-1:0]  divValue;
	logic                   sTick;
	chanStatus_t            chanStatus [numChannels];

	hostPort u_hostPort (
		.hostWr   (hostWr),
		.hostWord (hostWord),
		.push     (push),
		.pushData (pushData),
		.divLoad  (divLoad),
		.divValue (divValue)
	);

	baudTickGen u_baudTickGen (
		.clk      (clk),
		.reset    (reset),
		.divLoad  (divLoad),
		.divValue (divValue),
		.sTick    (sTick)
	);

	////////////////////////////////////////////////////////////
	// channels, all on the shared tick
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < numChannels; i++)
	begin : g_chan
		txChannel u_chan (
			.clk        (clk),
			.reset      (reset),
			.sTick      (sTick),
			.push       (push[i]),
			.pushData   (pushData),
			.tx         (tx[i]),
			.chanStatus (chanStatus[i])
		);
	end

	statusCollector u_statusCollector (
		.clk          (clk),
		.reset        (reset),
		.chanStatusIn (chanStatus),
		.statusSel    (statusSel),
		.statusRd     (statusRd),
		.status       (status)
	);

endmodule

`default_nettype wire

// ==== testbench/txChecker.sv ====
// tx line checker
`default_nettype none

module txChecker (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [uartTxPkg::numChannels-1:0] tx,
	input  uartTxPkg::chanStatus_t            status,
	input  logic [uartTxPkg::divisorLen-1:0]  divisor	// rate frames are decoded at
);
	import uartTxPkg::*;

	localparam int frameLen = dataBits + 2;	// start, data, one stop

	logic [dataBits-1:0] expQ [numChannels][$];	// bytes still owed per line
	int errorCount = 0;
	int testCount  = 0;
	int okCount    = 0;
	int errAtStart = 0;		// error count when the current test began

	// line levels of one frame, bit 0 goes out first
	function automatic logic [frameLen-1:0] frameBits(input logic [dataBits-1:0] b);
		return {1'b1, b, 1'b0};	// stop, data msb..lsb, start
	endfunction

	task automatic reportError(input string msg);
		errorCount++;
		$display("CHECK FAILED at time %0t: %s", $time, msg);
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("error at time %0t: %s", $time, msg);
	endtask

	task automatic expectByte(input logic [chanIdxLen-1:0] ch, input logic [dataBits-1:0] b);
		expQ[ch].push_back(b);
	endtask

	////////////////////////////////////////////////////////////
	// frame decode, one watcher per line
	////////////////////////////////////////////////////////////

	task automatic decodeFrame(input logic [chanIdxLen-1:0] ch);
		int                  clocksPerBit;
		logic [frameLen-1:0] got;
		logic [frameLen-1:0] want;
		logic [dataBits-1:0] b;
		clocksPerBit = 16 * (int'(divisor) + 1);	// 16 ticks per bit
		repeat (clocksPerBit / 2) @(negedge clk);	// middle of start bit
		got = {tx[ch], {(frameLen-1){1'b0}}};
		for (int i = 1; i < frameLen; i++)
		begin
			repeat (clocksPerBit) @(negedge clk);
			got = {tx[ch], got[frameLen-1:1]};	// first sample ends in bit 0
		end
		if (expQ[ch].size() == 0)
			reportProblem($sformatf("channel %0d sent a frame nobody wrote, data %h",
				ch, got[dataBits:1]));
		else
		begin
			b    = expQ[ch].pop_front();
			want = frameBits(b);
			if (!got[frameLen-1])
				reportProblem($sformatf("the stop bit on channel %0d was low", ch));
			else if (got !== want)
				reportError($sformatf("channel %0d frame %b, expected %b for byte %h",
					ch, got, want, b));
		end
	endtask

	task automatic watchLine(input logic [chanIdxLen-1:0] ch);
		logic prevLevel;
		prevLevel = 1'b1;
		forever
		begin
			@(negedge clk);
			if (!reset && prevLevel && !tx[ch])
				decodeFrame(ch);	// returns inside the stop bit
			prevLevel = tx[ch];
		end
	endtask

	initial
	begin
		for (int c = 0; c < numChannels; c++)
		begin
			fork
				automatic logic [chanIdxLen-1:0] ch = chanIdxLen'(c);
				watchLine(ch);
			join_none
		end
	end

	////////////////////////////////////////////////////////////
	// checks called by the test sequence
	////////////////////////////////////////////////////////////

	task automatic expectLines(input logic [numChannels-1:0] want);
		if (tx !== want)
			reportError($sformatf("tx lines %b, expected %b", tx, want));
	endtask

	task automatic expectStatus(input string what, input logic ovf, input logic busy,
			input logic empty, input int lvlLo, input int lvlHi);
		if (status.overflow !== ovf || status.busy !== busy || status.empty !== empty
				|| int'(status.level) < lvlLo || int'(status.level) > lvlHi)
			reportError($sformatf("%s: ovf %b busy %b empty %b level %0d, expected %b %b %b %0d..%0d",
				what, status.overflow, status.busy, status.empty, status.level,
				ovf, busy, empty, lvlLo, lvlHi));
	endtask

	task automatic leftoverCheck(input logic [chanIdxLen-1:0] ch);
		if (expQ[ch].size() != 0)
			reportProblem($sformatf("channel %0d never sent %0d expected bytes",
				ch, expQ[ch].size()));
		expQ[ch].delete();
	endtask

	task automatic finishTest(input string name);
		for (int c = 0; c < numChannels; c++)
			leftoverCheck(chanIdxLen'(c));
		testCount++;
		if (errorCount == errAtStart)
		begin
			okCount++;
			$display("test %0d %s: ok", testCount, name);
		end
		else
			$display("test %0d %s: FAILED with %0d errors", testCount, name,
				errorCount - errAtStart);
		errAtStart = errorCount;
	endtask

	task automatic printSummary();
		$display("summary: %0d run, %0d ok, %0d failing, %0d errors",
			testCount, okCount, testCount - okCount, errorCount);
	endtask

endmodule

`default_nettype wire

// ==== testbench/tbUartTxBank.sv ====
// uart transmit bank testbench
`default_nettype none

module tbUartTxBank;
	import uartTxPkg::*;

	localparam int totalBytes   = 56;	// every byte written, dropped ones too
	localparam int maxDivisor   = 7;
	localparam int watchdogTime = totalBytes * 10 * 16 * (maxDivisor + 1) * 2 * 10 + 100000;

	logic                   clk;
	logic                   reset;
	logic                   hostWr;
	hostWord_t              hostWord;
	logic [chanIdxLen-1:0]  statusSel;
	logic                   statusRd;
	chanStatus_t            status;
	logic [numChannels-1:0] tx;
	logic [divisorLen-1:0]  divisor;	// mirrors the bank's divisor for decoding
	logic [31:0]            lfsrState;

	uartTxBank UUT (
		.clk       (clk),
		.reset     (reset),
		.hostWr    (hostWr),
		.hostWord  (hostWord),
		.statusSel (statusSel),
		.statusRd  (statusRd),
		.status    (status),
		.tx        (tx)
	);

	txChecker lineCheck (
		.clk     (clk),
		.reset   (reset),
		.tx      (tx),
		.status  (status),
		.divisor (divisor)
	);

	always #5 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic nextByte(output logic [dataBits-1:0] b);
		b = '0;
		for (int i = 0; i < dataBits; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			b = {lfsrState[0], b[dataBits-1:1]};	// first bit lands in lsb
		end
	endtask

	////////////////////////////////////////////////////////////
	// host side tasks, all start and end on a falling edge
	////////////////////////////////////////////////////////////

	task automatic writeByte(input logic [chanIdxLen-1:0] ch, input logic [dataBits-1:0] b,
			input bit owed);
		hostWord              = '0;	// tag 0, data view
		hostWord.data.channel = ch;
		hostWord.data.payload = b;
		hostWr                = 1'b1;
		if (owed)
			lineCheck.expectByte(ch, b);
		@(negedge clk);
	endtask

	task automatic writeDivisor(input logic [divisorLen-1:0] d);
		hostWord              = '0;
		hostWord.cfg.isConfig = 1'b1;
		hostWord.cfg.divisor  = d;
		hostWr                = 1'b1;
		divisor               = d;
		@(negedge clk);
		hostWr = 1'b0;
	endtask

	task automatic selectChannel(input logic [chanIdxLen-1:0] ch);
		hostWr    = 1'b0;
		statusSel = ch;
		@(negedge clk);	// status is one clock behind
	endtask

	task automatic waitIdle();
		for (int c = 0; c < numChannels; c++)
		begin
			selectChannel(chanIdxLen'(c));
			while (status.busy)
				@(negedge clk);
		end
	endtask

	initial
	begin
		logic [dataBits-1:0] b;
		clk       = 1'b0;
		reset     = 1'b1;
		hostWr    = 1'b0;
		hostWord  = '0;
		statusSel = '0;
		statusRd  = 1'b0;
		divisor   = defaultDivisor;
		lfsrState = 32'hb708_3829;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// idle lines and clean status out of reset
		lineCheck.expectLines('1);
		for (int c = 0; c < numChannels; c++)
		begin
			selectChannel(chanIdxLen'(c));
			lineCheck.expectStatus($sformatf("channel %0d after reset", c),
				1'b0, 1'b0, 1'b1, 0, 0);
		end
		lineCheck.finishTest("reset state");

		writeByte(chanIdxLen'(0), 8'h35, 1'b1);	// asymmetric, shows bit order
		waitIdle();
		lineCheck.finishTest("single byte");

		for (int k = 0; k < 4; k++)
		begin
			for (int c = 0; c < numChannels; c++)
			begin
				nextByte(b);
				writeByte(chanIdxLen'(c), b, 1'b1);
			end
		end
		waitIdle();
		lineCheck.finishTest("all channels");

		////////////////////////////////////////////////////////////
		// fifo depth, overflow, divisor change
		////////////////////////////////////////////////////////////

		for (int i = 0; i < fifoDepth; i++)
		begin
			nextByte(b);
			writeByte(chanIdxLen'(2), b, 1'b1);
		end
		selectChannel(chanIdxLen'(2));
		lineCheck.expectStatus("channel 2 after burst", 1'b0, 1'b1, 1'b0, 15, 16);
		waitIdle();
		selectChannel(chanIdxLen'(2));
		lineCheck.expectStatus("channel 2 drained", 1'b0, 1'b0, 1'b1, 0, 0);
		lineCheck.finishTest("burst of 16");

		// 1 taken by the fsm plus 16 stored, last 3 dropped
		for (int i = 0; i < 20; i++)
		begin
			nextByte(b);
			writeByte(chanIdxLen'(3), b, i < 17);
		end
		selectChannel(chanIdxLen'(3));
		lineCheck.expectStatus("channel 3 overflowed", 1'b1, 1'b1, 1'b0, 16, 16);
		statusRd = 1'b1;
		@(negedge clk);
		statusRd = 1'b0;
		@(negedge clk);
		lineCheck.expectStatus("channel 3 after read", 1'b0, 1'b1, 1'b0, 16, 16);
		waitIdle();
		lineCheck.finishTest("overflow");

		writeDivisor(15'd7);	// 128 clocks per bit
		nextByte(b);
		writeByte(chanIdxLen'(1), b, 1'b1);
		nextByte(b);
		writeByte(chanIdxLen'(1), b, 1'b1);
		nextByte(b);
		writeByte(chanIdxLen'(0), b, 1'b1);
		waitIdle();
		lineCheck.finishTest("divisor 7");

		lineCheck.printSummary();
		if (lineCheck.errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// worst case every byte at the slowest rate, twice over
	initial
	begin
		#(watchdogTime);
		$display("watchdog: the run did not finish within %0d time units", watchdogTime);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/uartTxPkg.sv
hdl/baudTickGen.sv
hdl/uartTrans.sv
hdl/txChannel.sv
hdl/hostPort.sv
hdl/statusCollector.sv
hdl/uartTxBank.sv
testbench/txChecker.sv
testbench/tbUartTxBank.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uart bank testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tbUartTxBank -f flist.f -o simTb
./obj_dir/simTb | tee sim.log
if grep -qx "all tests passed" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
